//--- logic/mb_dc_quant.sv
/*
 * DC prediction and quantizer of the block encoder
 * Two-stage pipeline where stage 1 predicts and stage 2
 * quantizes, reconstructs and counts nonzero levels
 */
`default_nettype none

module mb_dc_quant
    import mb_encode_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    mb_block_if.exec blk,
    mb_job_if.exec   job
);

    logic [PIX_W+2:0] edge_sum;
    pixel_t           pred_c;
    logic             s1_valid;
    pixel_t           s1_pred;
    block_t           s1_pix;
    logic [POS_W-1:0] s1_x;
    logic [POS_W-1:0] s1_y;
    level_blk_t       lvl_c;
    block_t           rec_c;
    logic [NZ_W-1:0]  nz_c;

    function automatic level_t quant_pix(pixel_t p, pixel_t pr, logic [QSHIFT_W-1:0] qs);
        logic signed [PIX_W:0] diff;
        diff = $signed({1'b0, p}) - $signed({1'b0, pr});
        diff = diff >>> qs;
        // Saturate to the level range
        if (diff > 9'sd127) begin
            return 8'sd127;
        end
        if (diff < -9'sd128) begin
            return -8'sd128;
        end
        return level_t'(diff);
    endfunction

    function automatic pixel_t recon_pix(level_t lv, pixel_t pr, logic [QSHIFT_W-1:0] qs);
        logic signed [PIX_W+3:0] val;
        val = $signed({4'b0, pr}) + ($signed({{4{lv[PIX_W-1]}}, lv}) <<< qs);
        if (val < 0) begin
            return '0;
        end
        if (val > 255) begin
            return 8'd255;
        end
        return val[PIX_W-1:0];
    endfunction

    // --------------------------------------------------
    // Stage 1 DC prediction
    // --------------------------------------------------
    always_comb begin
        edge_sum = '0;
        for (int i = 0; i < MB_DIM; i++) begin
            edge_sum = edge_sum + blk.top[i] + blk.left[i];
        end
        pred_c = pixel_t'((edge_sum + 4) >> 3);
    end

    always_ff @(posedge clk) begin
        s1_pred <= pred_c;
        s1_pix  <= blk.pix;
        s1_x    <= blk.x;
        s1_y    <= blk.y;
    end

    // --------------------------------------------------
    // Stage 2 quantization and reconstruction
    // --------------------------------------------------
    always_comb begin
        nz_c = '0;
        for (int i = 0; i < MB_PIX; i++) begin
            lvl_c[i] = quant_pix(s1_pix[i], s1_pred, blk.qshift);
            rec_c[i] = recon_pix(lvl_c[i], s1_pred, blk.qshift);
            nz_c     = nz_c + NZ_W'(lvl_c[i] != '0);
        end
    end

    always_ff @(posedge clk) begin
        job.levels <= lvl_c;
        job.recon  <= rec_c;
        job.pred   <= s1_pred;
        job.nz     <= nz_c;
        job.x      <= s1_x;
        job.y      <= s1_y;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            job.valid <= 1'b0;
        end else begin
            s1_valid  <= blk.start;
            job.valid <= s1_valid;
        end
    end

endmodule

`default_nettype wire

//--- logic/mb_encode_pkg.sv
/*
 * Intra block encoder shared definitions
 * Block sizes, pixel and level types, output beat layout
 */
`default_nettype none

package mb_encode_pkg;

    // Block geometry
    localparam int MB_DIM      = 4;
    localparam int MB_PIX      = MB_DIM * MB_DIM;
    localparam int PIX_W       = 8;
    localparam int MAX_MB_COLS = 8;
    localparam int MAX_MB_ROWS = 8;
    localparam int POS_W       = $clog2(MAX_MB_COLS > MAX_MB_ROWS ? MAX_MB_COLS : MAX_MB_ROWS);
    localparam int DIM_W       = POS_W + 1;
    localparam int QSHIFT_W    = 2;
    localparam int NZ_W        = 5;

    // --------------------------------------------------
    // Output beat layout
    // --------------------------------------------------
    localparam int BEAT_W       = 64;
    localparam int BEATS_PER_MB = 3;
    localparam int BEAT_CNT_W   = 2;
    localparam int B2_PRED_LSB  = 0;
    localparam int B2_NZ_LSB    = 8;
    localparam int B2_X_LSB     = 16;
    localparam int B2_Y_LSB     = 24;

    typedef logic [PIX_W-1:0]        pixel_t;
    typedef logic signed [PIX_W-1:0] level_t;
    typedef pixel_t [MB_PIX-1:0]     block_t;
    typedef level_t [MB_PIX-1:0]     level_blk_t;
    typedef pixel_t [MB_DIM-1:0]     edge_t;

    // Neighbour defaults outside the frame
    localparam pixel_t EDGE_TOP  = 8'd127;
    localparam pixel_t EDGE_LEFT = 8'd129;

endpackage

`default_nettype wire

//--- logic/mb_encode_top.sv
/*
 * Intra block encoder top level
 * Scan controller, DC quantizer, neighbour store and packer
 */
`default_nettype none

module mb_encode_top
    import mb_encode_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic [DIM_W-1:0]    mb_cols,
    input  logic [DIM_W-1:0]    mb_rows,
    input  logic [QSHIFT_W-1:0] qshift,
    input  block_t              in_data,
    input  logic                in_empty,
    output logic                in_rd,
    input  logic                out_full,
    output logic                out_wr,
    output logic [BEAT_W-1:0]   out_data,
    output logic                done
);

    mb_block_if blk_if ();
    mb_job_if   job_if ();

    mb_scan_ctrl u_scan_ctrl (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .start    ( start    ),
        .mb_cols  ( mb_cols  ),
        .mb_rows  ( mb_rows  ),
        .in_empty ( in_empty ),
        .in_data  ( in_data  ),
        .qshift   ( qshift   ),
        .in_rd    ( in_rd    ),
        .done     ( done     ),
        .blk      ( blk_if   ),
        .job      ( job_if   )
    );

    mb_neighbor_store u_neighbor_store (
        .clk   ( clk    ),
        .rst_n ( rst_n  ),
        .blk   ( blk_if ),
        .job   ( job_if )
    );

    mb_dc_quant u_dc_quant (
        .clk   ( clk    ),
        .rst_n ( rst_n  ),
        .blk   ( blk_if ),
        .job   ( job_if )
    );

    mb_result_pack u_result_pack (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .out_full ( out_full ),
        .out_wr   ( out_wr   ),
        .out_data ( out_data ),
        .job      ( job_if   )
    );

endmodule

`default_nettype wire

//--- logic/mb_if.sv
/*
 * Block and job interfaces of the block encoder
 * mb_block_if carries the issued block and its neighbours
 * while mb_job_if carries the quantized result to the packer
 */
`default_nettype none

interface mb_block_if import mb_encode_pkg::*; ();

    logic                start;
    block_t              pix;
    logic [POS_W-1:0]    x;
    logic [POS_W-1:0]    y;
    edge_t               top;
    edge_t               left;
    logic [QSHIFT_W-1:0] qshift;

    modport ctrl  (output start, pix, x, y, qshift);
    modport store (input x, y, output top, left);
    modport exec  (input start, pix, x, y, top, left, qshift);

endinterface

interface mb_job_if import mb_encode_pkg::*; ();

    logic             valid;
    level_blk_t       levels;
    block_t           recon;
    pixel_t           pred;
    logic [NZ_W-1:0]  nz;
    logic [POS_W-1:0] x;
    logic [POS_W-1:0] y;
    logic             done;

    modport exec    (output valid, levels, recon, pred, nz, x, y);
    modport result  (input valid, levels, pred, nz, x, y, output done);
    // Neighbour store snoops the reconstruction
    modport monitor (input valid, recon, x);
    modport ctrl    (input done);

endinterface

`default_nettype wire

//--- logic/mb_neighbor_store.sv
/*
 * Neighbour store of the block encoder
 * Keeps the left column and a top-row line buffer from the
 * reconstruction and applies the frame edge defaults
 */
`default_nettype none

module mb_neighbor_store
    import mb_encode_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    mb_block_if.store   blk,
    mb_job_if.monitor   job
);

    edge_t left_q;
    edge_t top_line [MAX_MB_COLS];
    edge_t recon_col;
    edge_t recon_row;

    // Right column and bottom row of the finished block
    always_comb begin
        for (int i = 0; i < MB_DIM; i++) begin
            recon_col[i] = job.recon[i * MB_DIM + (MB_DIM - 1)];
            recon_row[i] = job.recon[(MB_DIM - 1) * MB_DIM + i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_q <= {MB_DIM{EDGE_LEFT}};
        end else if (job.valid) begin
            left_q <= recon_col;
        end
    end

    // One top row per block column
    always_ff @(posedge clk) begin
        if (job.valid) begin
            top_line[job.x] <= recon_row;
        end
    end

    // --------------------------------------------------
    // Neighbours for the current block
    // --------------------------------------------------
    assign blk.left = (blk.x == '0) ? {MB_DIM{EDGE_LEFT}} : left_q;
    assign blk.top  = (blk.y == '0) ? {MB_DIM{EDGE_TOP}} : top_line[blk.x];

endmodule

`default_nettype wire

//--- logic/mb_result_pack.sv
/*
 * Beat packer of the block encoder
 * Serializes one job into three output FIFO beats and
 * stalls while the FIFO is full
 */
`default_nettype none

module mb_result_pack
    import mb_encode_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              out_full,
    output logic              out_wr,
    output logic [BEAT_W-1:0] out_data,
    mb_job_if.result          job
);

    logic [BEAT_W-1:0]     beat_q [BEATS_PER_MB];
    logic [BEAT_W-1:0]     info_beat;
    logic [BEAT_CNT_W-1:0] beat_cnt;
    logic                  busy;
    logic                  issue;
    logic                  last_beat;

    // Prediction, count and position beat
    always_comb begin
        info_beat = '0;
        info_beat[B2_PRED_LSB +: PIX_W] = job.pred;
        info_beat[B2_NZ_LSB +: NZ_W]    = job.nz;
        info_beat[B2_X_LSB +: POS_W]    = job.x;
        info_beat[B2_Y_LSB +: POS_W]    = job.y;
    end

    always_ff @(posedge clk) begin
        if (job.valid) begin
            beat_q[0] <= job.levels[MB_PIX/2-1:0];
            beat_q[1] <= job.levels[MB_PIX-1:MB_PIX/2];
            beat_q[2] <= info_beat;
        end
    end

    // Full is sampled at the edge that launches the write
    assign issue = busy && !out_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            beat_cnt  <= '0;
            out_wr    <= 1'b0;
            last_beat <= 1'b0;
            job.done  <= 1'b0;
        end else begin
            out_wr    <= issue;
            last_beat <= 1'b0;
            job.done  <= last_beat;
            if (issue) begin
                if (beat_cnt == BEAT_CNT_W'(BEATS_PER_MB - 1)) begin
                    busy      <= 1'b0;
                    beat_cnt  <= '0;
                    last_beat <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end else if (job.valid) begin
                busy <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            out_data <= beat_q[beat_cnt];
        end
    end

endmodule

`default_nettype wire

//--- logic/mb_scan_ctrl.sv
/*
 * Scan controller of the block encoder
 * Walks the frame in raster order, pops blocks from the
 * input FIFO and issues them one at a time
 */
`default_nettype none

module mb_scan_ctrl
    import mb_encode_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic [DIM_W-1:0]    mb_cols,
    input  logic [DIM_W-1:0]    mb_rows,
    input  logic                in_empty,
    input  block_t              in_data,
    input  logic [QSHIFT_W-1:0] qshift,
    output logic                in_rd,
    output logic                done,
    mb_block_if.ctrl            blk,
    mb_job_if.ctrl              job
);

    typedef enum logic [5:0] {
        IDLE  = 6'b000001,
        READ  = 6'b000010,
        ISSUE = 6'b000100,
        WAIT  = 6'b001000,
        NEXT  = 6'b010000,
        DONE  = 6'b100000
    } state_t;

    state_t           state;
    state_t           state_nxt;
    block_t           pix_q;
    logic [POS_W-1:0] x_q;
    logic [POS_W-1:0] y_q;
    logic             last_col;
    logic             last_row;

    assign last_col = (DIM_W'(x_q) == mb_cols - 1'b1);
    assign last_row = (DIM_W'(y_q) == mb_rows - 1'b1);

    // --------------------------------------------------
    // Frame walk FSM
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    state_nxt = start ? READ : IDLE;
            READ:    state_nxt = in_empty ? READ : ISSUE;
            ISSUE:   state_nxt = WAIT;
            WAIT:    state_nxt = !job.done ? WAIT : ((last_col && last_row) ? DONE : NEXT);
            NEXT:    state_nxt = READ;
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // Block position in raster order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_q <= '0;
            y_q <= '0;
        end else if (state == IDLE && start) begin
            x_q <= '0;
            y_q <= '0;
        end else if (state == NEXT) begin
            x_q <= last_col ? '0 : x_q + 1'b1;
            y_q <= last_col ? y_q + 1'b1 : y_q;
        end
    end

    always_ff @(posedge clk) begin
        if (in_rd) begin
            pix_q <= in_data;
        end
    end

    assign in_rd      = (state == READ) && !in_empty;
    assign done       = (state == DONE);
    assign blk.start  = (state == ISSUE);
    assign blk.pix    = pix_q;
    assign blk.x      = x_q;
    assign blk.y      = y_q;
    assign blk.qshift = qshift;

endmodule

`default_nettype wire

//--- mb_encode.f
logic/mb_encode_pkg.sv
logic/mb_if.sv
logic/mb_scan_ctrl.sv
logic/mb_neighbor_store.sv
logic/mb_dc_quant.sv
logic/mb_result_pack.sv
logic/mb_encode_top.sv
testbench/mb_encode_properties.sv
testbench/tb_mb_encode.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the block encoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_mb_encode
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f mb_encode.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- testbench/mb_encode_properties.sv
/*
 * Protocol checks on the block encoder top level
 * FIFO handshakes and the frame done pulse
 */
`default_nettype none

module mb_encode_properties (
    input logic clk,
    input logic rst_n,
    input logic in_rd,
    input logic in_empty,
    input logic out_full,
    input logic out_wr,
    input logic done
);
    timeunit 1ns;
    timeprecision 100ps;

    // Read strobe only against a non-empty FIFO
    rd_not_empty_a: assert property (@(posedge clk) disable iff (!rst_n) in_rd |-> !in_empty)
        else $error("input FIFO read while it was empty");

    // Full seen at one edge blocks the write launched there
    wr_after_full_a: assert property (@(posedge clk) disable iff (!rst_n) out_full |=> !out_wr)
        else $error("output FIFO written in the cycle after full");

    done_pulse_a: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done stayed high for more than one cycle");

endmodule

bind mb_encode_top mb_encode_properties u_properties (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .in_rd    ( in_rd    ),
    .in_empty ( in_empty ),
    .out_full ( out_full ),
    .out_wr   ( out_wr   ),
    .done     ( done     )
);

`default_nettype wire

//--- testbench/tb_mb_encode.sv
/*
 * Testbench of the intra block encoder
 * Directed frames against a reference model using input FIFO
 * and output sink models and a watchdog
 */
`default_nettype none

module tb_mb_encode
    import mb_encode_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                start;
    logic [DIM_W-1:0]    mb_cols;
    logic [DIM_W-1:0]    mb_rows;
    logic [QSHIFT_W-1:0] qshift;
    block_t              in_data;
    logic                in_empty;
    logic                in_rd;
    logic                out_full;
    logic                out_wr;
    logic [BEAT_W-1:0]   out_data;
    logic                done;

    block_t            frame_pix[$];
    block_t            in_queue[$];
    logic [BEAT_W-1:0] exp_beats[$];
    logic [BEAT_W-1:0] beats_got[$];
    logic [31:0]       pix_rng;
    logic [31:0]       full_rng;
    bit                rd_seen;
    bit                rd_empty;
    bit                full_prev;
    bit                full_random;
    int                gap_len;
    int                gap_left;
    int                read_count;
    int                done_count;
    int                error_count;
    int                beats_checked;

    mb_encode_top DUT (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .start    ( start    ),
        .mb_cols  ( mb_cols  ),
        .mb_rows  ( mb_rows  ),
        .qshift   ( qshift   ),
        .in_data  ( in_data  ),
        .in_empty ( in_empty ),
        .in_rd    ( in_rd    ),
        .out_full ( out_full ),
        .out_wr   ( out_wr   ),
        .out_data ( out_data ),
        .done     ( done     )
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // --------------------------------------------------
    // FIFO models serviced on the falling edge
    // --------------------------------------------------
    always @(posedge clk) begin
        rd_seen  <= in_rd;
        rd_empty <= in_rd && in_empty;
    end

    always @(negedge clk) begin
        if (rd_seen) begin
            read_count++;
            assert (!rd_empty) else begin
                error_count++;
                $display("Input FIFO was read while it signalled empty at %0t", $time);
            end
            assert (in_queue.size() > 0) else begin
                error_count++;
                $display("Input FIFO read at %0t with no block queued", $time);
            end
            if (in_queue.size() > 0) begin
                in_queue.delete(0);
            end
            gap_left = gap_len;
        end else if (gap_left > 0) begin
            gap_left--;
        end
        if (out_wr) begin
            assert (!full_prev) else begin
                error_count++;
                $display("Output beat written at %0t although the FIFO was full", $time);
            end
            beats_got.push_back(out_data);
        end
        if (done) begin
            done_count++;
        end
        in_empty = (in_queue.size() == 0) || (gap_left != 0);
        in_data  = (in_queue.size() > 0) ? in_queue[0] : '0;
        if (full_random) begin
            full_rng = xorshift32(full_rng);
            out_full = full_rng[7];
        end else begin
            out_full = 1'b0;
        end
        full_prev = out_full;
    end

    // --------------------------------------------------
    // Reference model of DC prediction per block in raster order
    // --------------------------------------------------
    function automatic void model_frame(input int cols, input int rows, input int qs);
        int                top_mem [MAX_MB_COLS][MB_DIM];
        int                left_mem [MB_DIM];
        int                recon [MB_PIX];
        int                sum;
        int                pred;
        int                diff;
        int                lvl;
        int                rec;
        int                nz;
        block_t            b;
        logic [BEAT_W-1:0] b0;
        logic [BEAT_W-1:0] b1;
        logic [BEAT_W-1:0] b2;
        exp_beats.delete();
        for (int y = 0; y < rows; y++) begin
            for (int x = 0; x < cols; x++) begin
                b   = frame_pix[y * cols + x];
                sum = 0;
                for (int i = 0; i < MB_DIM; i++) begin
                    sum += (y == 0) ? int'(EDGE_TOP) : top_mem[x][i];
                    sum += (x == 0) ? int'(EDGE_LEFT) : left_mem[i];
                end
                pred = (sum + 4) >>> 3;
                nz   = 0;
                b0   = '0;
                b1   = '0;
                for (int i = 0; i < MB_PIX; i++) begin
                    diff = int'(b[i]) - pred;
                    lvl  = diff >>> qs;
                    lvl  = (lvl > 127) ? 127 : ((lvl < -128) ? -128 : lvl);
                    if (lvl != 0) begin
                        nz++;
                    end
                    rec      = pred + lvl * (1 << qs);
                    recon[i] = (rec < 0) ? 0 : ((rec > 255) ? 255 : rec);
                    if (i < 8) begin
                        b0[8*i +: 8] = lvl[7:0];
                    end else begin
                        b1[8*(i-8) +: 8] = lvl[7:0];
                    end
                end
                b2        = '0;
                b2[7:0]   = pred[7:0];
                b2[12:8]  = nz[4:0];
                b2[18:16] = x[2:0];
                b2[26:24] = y[2:0];
                exp_beats.push_back(b0);
                exp_beats.push_back(b1);
                exp_beats.push_back(b2);
                // Right column and bottom row feed later blocks
                for (int i = 0; i < MB_DIM; i++) begin
                    left_mem[i]   = recon[i * MB_DIM + 3];
                    top_mem[x][i] = recon[3 * MB_DIM + i];
                end
            end
        end
    endfunction

    task automatic add_random_blocks(input int count);
        logic [MB_PIX*8-1:0] flat;
        for (int n = 0; n < count; n++) begin
            for (int w = 0; w < MB_PIX / 4; w++) begin
                pix_rng         = xorshift32(pix_rng);
                flat[32*w +: 32] = pix_rng;
            end
            frame_pix.push_back(block_t'(flat));
        end
    endtask

    task automatic wait_frame_done(input int limit, output bit seen);
        seen = 1'b0;
        for (int c = 0; c < limit && !seen; c++) begin
            @(negedge clk);
            if (done) begin
                seen = 1'b1;
            end
        end
    endtask

    task automatic compare_beats();
        assert (beats_got.size() == exp_beats.size()) else begin
            error_count++;
            $display("Error at %0t: out_wr beat count got %0d, expected %0d",
                     $time, beats_got.size(), exp_beats.size());
        end
        foreach (exp_beats[i]) begin
            if (i < beats_got.size()) begin
                beats_checked++;
                assert (beats_got[i] == exp_beats[i]) else begin
                    error_count++;
                    $display("Error at %0t: out_data beat %0d got %h, expected %h",
                             $time, i, beats_got[i], exp_beats[i]);
                end
            end
        end
    endtask

    // Queues frame_pix, runs one frame and checks every beat
    task automatic run_frame(input int cols, input int rows, input int qs,
                             input int gap, input bit full_rand);
        bit seen;
        int done_before;
        int reads_before;
        model_frame(cols, rows, qs);
        beats_got.delete();
        done_before  = done_count;
        reads_before = read_count;
        gap_len      = gap;
        full_random  = full_rand;
        foreach (frame_pix[i]) begin
            in_queue.push_back(frame_pix[i]);
        end
        @(negedge clk);
        mb_cols = cols[DIM_W-1:0];
        mb_rows = rows[DIM_W-1:0];
        qshift  = qs[QSHIFT_W-1:0];
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_frame_done(cols * rows * 40 + 50, seen);
        assert (seen) else begin
            error_count++;
            $display("Frame of %0dx%0d blocks never raised done", cols, rows);
        end
        full_random = 1'b0;
        repeat (2) @(negedge clk);
        compare_beats();
        assert (done_count - done_before == 1) else begin
            error_count++;
            $display("Error at %0t: done pulses got %0d, expected 1",
                     $time, done_count - done_before);
        end
        assert (read_count - reads_before == cols * rows) else begin
            error_count++;
            $display("Error at %0t: in_rd reads got %0d, expected %0d",
                     $time, read_count - reads_before, cols * rows);
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_flat_block();
        $display("Flat 1x1 block at 128");
        frame_pix.delete();
        frame_pix.push_back({MB_PIX{8'd128}});
        run_frame(1, 1, 0, 0, 1'b0);
        // Edges 4*127 + 4*129 give a DC of 128
        if (beats_got.size() == 3) begin
            assert (beats_got[2][7:0] == 8'd128) else begin
                error_count++;
                $display("Error at %0t: out_data pred got %0d, expected 128",
                         $time, beats_got[2][7:0]);
            end
            assert (beats_got[2][12:8] == 5'd0) else begin
                error_count++;
                $display("Error at %0t: out_data nz got %0d, expected 0",
                         $time, beats_got[2][12:8]);
            end
        end
    endtask

    task automatic test_random_frame();
        $display("Random 3x2 frame, qshift 2");
        frame_pix.delete();
        add_random_blocks(6);
        run_frame(3, 2, 2, 0, 1'b0);
    endtask

    task automatic test_extreme_pixels();
        block_t b;
        $display("Extreme pixels 0 and 255, qshift 0");
        frame_pix.delete();
        frame_pix.push_back({MB_PIX{8'd0}});
        frame_pix.push_back({MB_PIX{8'd255}});
        for (int i = 0; i < MB_PIX; i++) begin
            b[i] = (((i / 4) + (i % 4)) % 2 == 1) ? 8'd255 : 8'd0;
        end
        frame_pix.push_back(b);
        // Bright neighbours push this DC above 128 so black saturates low
        frame_pix.push_back({MB_PIX{8'd0}});
        run_frame(2, 2, 0, 0, 1'b0);
    endtask

    task automatic test_output_backpressure();
        $display("Random 4x2 frame with output back-pressure");
        frame_pix.delete();
        add_random_blocks(8);
        run_frame(4, 2, 1, 0, 1'b1);
    endtask

    task automatic test_input_gaps();
        $display("2x2 frame with an empty input FIFO between blocks");
        frame_pix.delete();
        add_random_blocks(4);
        run_frame(2, 2, 3, 12, 1'b0);
    endtask

    task automatic test_back_to_back();
        $display("Two 2x2 frames back to back");
        frame_pix.delete();
        add_random_blocks(4);
        run_frame(2, 2, 0, 0, 1'b0);
        frame_pix.delete();
        add_random_blocks(4);
        run_frame(2, 2, 2, 0, 1'b0);
    endtask

    // 31 blocks over all tests at 40 cycles each plus slack
    initial begin
        repeat (31 * 40 + 400) @(posedge clk);
        $display("Watchdog expired before the tests completed");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        start    = 1'b0;
        mb_cols  = 1;
        mb_rows  = 1;
        qshift   = '0;
        in_data  = '0;
        in_empty = 1'b1;
        out_full = 1'b0;
        pix_rng  = 32'hb373_73a2;
        full_rng = xorshift32(32'hb373_73a2);
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_flat_block();
        test_random_frame();
        test_extreme_pixels();
        test_output_backpressure();
        test_input_gaps();
        test_back_to_back();
        $display("Summary: %0d errors, %0d beats compared", error_count, beats_checked);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
